// File: hw/mips_pkg.sv
package mips_pkg;

    localparam int DATA_W     = 32;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int REG_COUNT  = 32;
    localparam int SHAMT_W    = 5;
    localparam int IMM_W      = 16;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // primary opcode, inst[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL  = 6'b000000,
        OP_SPECIAL2 = 6'b011100,
        OP_ORI      = 6'b001101,
        OP_ANDI     = 6'b001100,
        OP_XORI     = 6'b001110,
        OP_LUI      = 6'b001111,
        OP_ADDI     = 6'b001000,
        OP_ADDIU    = 6'b001001,
        OP_SLTI     = 6'b001010,
        OP_SLTIU    = 6'b001011
    } opcode_e;

    // function field, inst[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_SRL  = 6'b000010,
        FN_SRA  = 6'b000011,
        FN_SLLV = 6'b000100,
        FN_SRLV = 6'b000110,
        FN_SRAV = 6'b000111,
        FN_MOVZ = 6'b001010,
        FN_MOVN = 6'b001011,
        FN_ADD  = 6'b100000,
        FN_ADDU = 6'b100001,
        FN_SUB  = 6'b100010,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_XOR  = 6'b100110,
        FN_NOR  = 6'b100111,
        FN_SLT  = 6'b101010,
        FN_SLTU = 6'b101011
    } funct_e;

    // SPECIAL2 reuses the ADD/ADDU codes
    localparam funct_e FN_CLZ = funct_e'(6'b100000);
    localparam funct_e FN_CLO = funct_e'(6'b100001);

    typedef enum logic [3:0] {
        ALU_NOP, ALU_OR, ALU_AND, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_CLZ, ALU_CLO, ALU_MOVE
    } alu_op_e;

endpackage

// File: hw/mips_decode.sv
`timescale 1ns/1ps

module mips_decode
(
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                inst_valid_i,
    input  mips_pkg::inst_t     inst_i,
    input  mips_pkg::word_t     rs_data_i,
    input  mips_pkg::word_t     rt_data_i,
    input  logic                ex_fwd_wen_i,
    input  mips_pkg::reg_addr_t ex_fwd_addr_i,
    input  mips_pkg::word_t     ex_fwd_data_i,
    input  logic                res_fwd_wen_i,
    input  mips_pkg::reg_addr_t res_fwd_addr_i,
    input  mips_pkg::word_t     res_fwd_data_i,
    output mips_pkg::reg_addr_t rs_addr_o,
    output mips_pkg::reg_addr_t rt_addr_o,
    output logic                id_valid_o,
    output mips_pkg::alu_op_e   id_op_o,
    output mips_pkg::word_t     id_opnd1_o,
    output mips_pkg::word_t     id_opnd2_o,
    output mips_pkg::reg_addr_t id_dest_o,
    output logic                id_wen_o,
    output logic                id_illegal_o
);
    import mips_pkg::*;

    opcode_e            opcode_f;
    funct_e             funct_f;
    reg_addr_t          rs_f;
    reg_addr_t          rt_f;
    reg_addr_t          rd_f;
    logic [SHAMT_W-1:0] shamt_f;
    logic [IMM_W-1:0]   imm_f;

    alu_op_e   op_c;
    reg_addr_t dest_c;
    word_t     imm_c;
    logic      rd1_c;
    logic      rd2_c;
    logic      wen_c;
    logic      legal_c;
    logic      movn_c;
    logic      movz_c;
    word_t     opnd1_c;
    word_t     opnd2_c;
    logic      write_c;

    // execute stage first, then result stage, then regfile
    function automatic word_t pick_operand(
        input logic      rd,
        input reg_addr_t addr,
        input word_t     rf_data,
        input word_t     alt,
        input logic      ex_wen,
        input reg_addr_t ex_addr,
        input word_t     ex_data,
        input logic      res_wen,
        input reg_addr_t res_addr,
        input word_t     res_data
    );
        if (!rd)
            return alt;
        else if (ex_wen && ex_addr == addr)
            return ex_data;
        else if (res_wen && res_addr == addr)
            return res_data;
        else
            return rf_data;
    endfunction

    assign opcode_f = opcode_e'(inst_i[31:26]);
    assign rs_f     = inst_i[25:21];
    assign rt_f     = inst_i[20:16];
    assign rd_f     = inst_i[15:11];
    assign shamt_f  = inst_i[10:6];
    assign funct_f  = funct_e'(inst_i[5:0]);
    assign imm_f    = inst_i[IMM_W-1:0];

    assign rs_addr_o = rs_f;
    assign rt_addr_o = rt_f;

    always_comb
    begin
        op_c    = ALU_NOP;
        dest_c  = rt_f;
        imm_c   = {{(DATA_W-IMM_W){imm_f[IMM_W-1]}}, imm_f}; // sign extended by default
        rd1_c   = 1'b1;
        rd2_c   = 1'b0;
        wen_c   = 1'b1;
        legal_c = 1'b1;
        movn_c  = 1'b0;
        movz_c  = 1'b0;
        case (opcode_f)
            OP_SPECIAL:
            begin
                dest_c  = rd_f;
                rd2_c   = 1'b1;
                legal_c = (shamt_f == '0);
                case (funct_f)
                    FN_OR:   op_c = ALU_OR;
                    FN_AND:  op_c = ALU_AND;
                    FN_XOR:  op_c = ALU_XOR;
                    FN_NOR:  op_c = ALU_NOR;
                    FN_SLLV: op_c = ALU_SLL;
                    FN_SRLV: op_c = ALU_SRL;
                    FN_SRAV: op_c = ALU_SRA;
                    FN_ADD, FN_ADDU: op_c = ALU_ADD; // no overflow trap
                    FN_SUB, FN_SUBU: op_c = ALU_SUB;
                    FN_SLT:  op_c = ALU_SLT;
                    FN_SLTU: op_c = ALU_SLTU;
                    FN_SLL, FN_SRL, FN_SRA:
                    begin
                        op_c    = (funct_f == FN_SLL) ? ALU_SLL :
                                  (funct_f == FN_SRL) ? ALU_SRL : ALU_SRA;
                        rd1_c   = 1'b0;
                        imm_c   = {{(DATA_W-SHAMT_W){1'b0}}, shamt_f};
                        legal_c = (rs_f == '0);
                    end
                    FN_MOVN, FN_MOVZ:
                    begin
                        op_c   = ALU_MOVE;
                        wen_c  = 1'b0; // decided by rt below
                        movn_c = (funct_f == FN_MOVN);
                        movz_c = (funct_f == FN_MOVZ);
                    end
                    default: legal_c = 1'b0;
                endcase
            end
            OP_SPECIAL2:
            begin
                dest_c = rd_f;
                case (funct_f)
                    FN_CLZ:  op_c = ALU_CLZ;
                    FN_CLO:  op_c = ALU_CLO;
                    default: legal_c = 1'b0;
                endcase
            end
            OP_ORI:   op_c = ALU_OR;
            OP_ANDI:  op_c = ALU_AND;
            OP_XORI:  op_c = ALU_XOR;
            OP_ADDI, OP_ADDIU: op_c = ALU_ADD;
            OP_SLTI:  op_c = ALU_SLT;
            OP_SLTIU: op_c = ALU_SLTU; // compares against the sign extended imm
            OP_LUI:
            begin
                op_c  = ALU_OR; // imm | imm
                rd1_c = 1'b0;
                imm_c = {imm_f, {(DATA_W-IMM_W){1'b0}}};
            end
            default: legal_c = 1'b0;
        endcase
        if (opcode_f == OP_ORI || opcode_f == OP_ANDI || opcode_f == OP_XORI)
            imm_c = {{(DATA_W-IMM_W){1'b0}}, imm_f};
        if (!legal_c)
        begin
            op_c   = ALU_NOP;
            wen_c  = 1'b0;
            movn_c = 1'b0;
            movz_c = 1'b0;
        end
    end

    assign opnd1_c = pick_operand(rd1_c, rs_f, rs_data_i, imm_c,
                                  ex_fwd_wen_i, ex_fwd_addr_i, ex_fwd_data_i,
                                  res_fwd_wen_i, res_fwd_addr_i, res_fwd_data_i);
    assign opnd2_c = pick_operand(rd2_c, rt_f, rt_data_i, imm_c,
                                  ex_fwd_wen_i, ex_fwd_addr_i, ex_fwd_data_i,
                                  res_fwd_wen_i, res_fwd_addr_i, res_fwd_data_i);

    assign write_c = (wen_c || (movn_c && opnd2_c != '0) || (movz_c && opnd2_c == '0))
                     && (dest_c != '0); // r0 never written

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            id_valid_o   <= 1'b0;
            id_wen_o     <= 1'b0;
            id_illegal_o <= 1'b0;
        end
        else
        begin
            id_valid_o   <= inst_valid_i;
            id_wen_o     <= inst_valid_i && write_c;
            id_illegal_o <= inst_valid_i && !legal_c;
        end
    end

    always_ff @(posedge clk)
    begin
        id_op_o    <= op_c;
        id_opnd1_o <= opnd1_c;
        id_opnd2_o <= opnd2_c;
        id_dest_o  <= dest_c;
    end

    a_illegal_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
        id_illegal_o |-> !id_wen_o);

endmodule

// File: hw/mips_execute.sv
`timescale 1ns/1ps

module mips_execute
(
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                id_valid_i,
    input  mips_pkg::alu_op_e   id_op_i,
    input  mips_pkg::word_t     id_opnd1_i,
    input  mips_pkg::word_t     id_opnd2_i,
    input  mips_pkg::reg_addr_t id_dest_i,
    input  logic                id_wen_i,
    input  logic                id_illegal_i,
    output logic                fwd_wen_o,
    output mips_pkg::reg_addr_t fwd_addr_o,
    output mips_pkg::word_t     fwd_data_o,
    output logic                ex_valid_o,
    output logic                ex_wen_o,
    output mips_pkg::reg_addr_t ex_dest_o,
    output mips_pkg::word_t     ex_result_o,
    output logic                ex_illegal_o
);
    import mips_pkg::*;

    logic [SHAMT_W-1:0] sh_amt;
    word_t              alu_res;

    // leading zeros from the msb, 0 to 32
    function automatic word_t lead_zeros(input word_t val);
        word_t cnt;
        logic  done;
        cnt  = '0;
        done = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--)
        begin
            if (!done && !val[i])
                cnt = cnt + 1'b1;
            else
                done = 1'b1;
        end
        return cnt;
    endfunction

    assign sh_amt = id_opnd1_i[SHAMT_W-1:0]; // low 5 bits only

    always_comb
    begin
        case (id_op_i)
            ALU_OR:   alu_res = id_opnd1_i | id_opnd2_i;
            ALU_AND:  alu_res = id_opnd1_i & id_opnd2_i;
            ALU_XOR:  alu_res = id_opnd1_i ^ id_opnd2_i;
            ALU_NOR:  alu_res = ~(id_opnd1_i | id_opnd2_i);
            ALU_SLL:  alu_res = id_opnd2_i << sh_amt;
            ALU_SRL:  alu_res = id_opnd2_i >> sh_amt;
            ALU_SRA:  alu_res = word_t'($signed(id_opnd2_i) >>> sh_amt);
            ALU_ADD:  alu_res = id_opnd1_i + id_opnd2_i; // wraps
            ALU_SUB:  alu_res = id_opnd1_i - id_opnd2_i;
            ALU_SLT:  alu_res = word_t'($signed(id_opnd1_i) < $signed(id_opnd2_i));
            ALU_SLTU: alu_res = word_t'(id_opnd1_i < id_opnd2_i);
            ALU_CLZ:  alu_res = lead_zeros(id_opnd1_i);
            ALU_CLO:  alu_res = lead_zeros(~id_opnd1_i);
            ALU_MOVE: alu_res = id_opnd1_i;
            default:  alu_res = '0;
        endcase
    end

    // wen already gated by valid and r0 upstream
    assign fwd_wen_o  = id_wen_i;
    assign fwd_addr_o = id_dest_i;
    assign fwd_data_o = alu_res;

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            ex_valid_o   <= 1'b0;
            ex_wen_o     <= 1'b0;
            ex_illegal_o <= 1'b0;
        end
        else
        begin
            ex_valid_o   <= id_valid_i;
            ex_wen_o     <= id_wen_i;
            ex_illegal_o <= id_illegal_i;
        end
    end

    always_ff @(posedge clk)
    begin
        ex_dest_o   <= id_dest_i;
        ex_result_o <= alu_res;
    end

    a_wen_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        ex_wen_o |-> ex_valid_o);

endmodule

// File: hw/mips_result.sv
`timescale 1ns/1ps

module mips_result
(
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                ex_valid_i,
    input  logic                ex_wen_i,
    input  mips_pkg::reg_addr_t ex_dest_i,
    input  mips_pkg::word_t     ex_result_i,
    input  logic                ex_illegal_i,
    input  mips_pkg::reg_addr_t rs_addr_i,
    input  mips_pkg::reg_addr_t rt_addr_i,
    output mips_pkg::word_t     rs_data_o,
    output mips_pkg::word_t     rt_data_o,
    output logic                res_valid_o,
    output logic                res_wen_o,
    output mips_pkg::reg_addr_t res_addr_o,
    output mips_pkg::word_t     res_data_o,
    output logic                res_illegal_o
);
    import mips_pkg::*;

    word_t regs [REG_COUNT];

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            for (int i = 0; i < REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (ex_wen_i && ex_dest_i != '0) // r0 stays zero
            regs[ex_dest_i] <= ex_result_i;
    end

    assign rs_data_o = regs[rs_addr_i];
    assign rt_data_o = regs[rt_addr_i];

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            res_valid_o   <= 1'b0;
            res_wen_o     <= 1'b0;
            res_illegal_o <= 1'b0;
        end
        else
        begin
            res_valid_o   <= ex_valid_i;
            res_wen_o     <= ex_wen_i;
            res_illegal_o <= ex_illegal_i;
        end
    end

    always_ff @(posedge clk)
    begin
        res_addr_o <= ex_dest_i;
        res_data_o <= ex_result_i;
    end

    a_res_wen_valid: assert property (@(posedge clk) disable iff (!rst_n_i)
        res_wen_o |-> res_valid_o);
    a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n_i)
        (rs_addr_i == '0) |-> (rs_data_o == '0));

endmodule

// File: hw/mips_core.sv
`timescale 1ns/1ps

module mips_core
(
    input  logic                clk,
    input  logic                rst_n_i,
    input  logic                inst_valid_i,
    input  mips_pkg::inst_t     inst_i,
    output logic                res_valid_o,
    output logic                res_wen_o,
    output mips_pkg::reg_addr_t res_addr_o,
    output mips_pkg::word_t     res_data_o,
    output logic                res_illegal_o
);
    import mips_pkg::*;

    reg_addr_t rs_addr;
    reg_addr_t rt_addr;
    word_t     rs_data;
    word_t     rt_data;

    logic      id_valid;
    alu_op_e   id_op;
    word_t     id_opnd1;
    word_t     id_opnd2;
    reg_addr_t id_dest;
    logic      id_wen;
    logic      id_illegal;

    logic      fwd_wen;
    reg_addr_t fwd_addr;
    word_t     fwd_data;

    logic      ex_valid;
    logic      ex_wen;
    reg_addr_t ex_dest;
    word_t     ex_result;
    logic      ex_illegal;

    mips_decode u_decode (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .inst_valid_i   (inst_valid_i),
        .inst_i         (inst_i),
        .rs_data_i      (rs_data),
        .rt_data_i      (rt_data),
        .ex_fwd_wen_i   (fwd_wen),   // instruction now in execute
        .ex_fwd_addr_i  (fwd_addr),
        .ex_fwd_data_i  (fwd_data),
        .res_fwd_wen_i  (ex_wen),    // instruction being written back
        .res_fwd_addr_i (ex_dest),
        .res_fwd_data_i (ex_result),
        .rs_addr_o      (rs_addr),
        .rt_addr_o      (rt_addr),
        .id_valid_o     (id_valid),
        .id_op_o        (id_op),
        .id_opnd1_o     (id_opnd1),
        .id_opnd2_o     (id_opnd2),
        .id_dest_o      (id_dest),
        .id_wen_o       (id_wen),
        .id_illegal_o   (id_illegal)
    );

    mips_execute u_execute (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .id_valid_i   (id_valid),
        .id_op_i      (id_op),
        .id_opnd1_i   (id_opnd1),
        .id_opnd2_i   (id_opnd2),
        .id_dest_i    (id_dest),
        .id_wen_i     (id_wen),
        .id_illegal_i (id_illegal),
        .fwd_wen_o    (fwd_wen),
        .fwd_addr_o   (fwd_addr),
        .fwd_data_o   (fwd_data),
        .ex_valid_o   (ex_valid),
        .ex_wen_o     (ex_wen),
        .ex_dest_o    (ex_dest),
        .ex_result_o  (ex_result),
        .ex_illegal_o (ex_illegal)
    );

    mips_result u_result (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .ex_valid_i    (ex_valid),
        .ex_wen_i      (ex_wen),
        .ex_dest_i     (ex_dest),
        .ex_result_i   (ex_result),
        .ex_illegal_i  (ex_illegal),
        .rs_addr_i     (rs_addr),
        .rt_addr_i     (rt_addr),
        .rs_data_o     (rs_data),
        .rt_data_o     (rt_data),
        .res_valid_o   (res_valid_o),
        .res_wen_o     (res_wen_o),
        .res_addr_o    (res_addr_o),
        .res_data_o    (res_data_o),
        .res_illegal_o (res_illegal_o)
    );

endmodule

// File: verification/mips_model.svh
`ifndef MIPS_MODEL_SVH
`define MIPS_MODEL_SVH

typedef struct packed {
    logic        wen;
    logic        illegal;
    logic        check_val; // addr and data only defined for legal encodings
    reg_addr_t   addr;
    word_t       data;
    logic [31:0] due;
} exp_t;

word_t model_regs [REG_COUNT];

function automatic word_t count_lead(input word_t v, input logic bit_val);
    word_t n;
    n = '0;
    for (int i = DATA_W - 1; i >= 0; i--)
    begin
        if (v[i] == bit_val && n == word_t'(DATA_W - 1 - i))
            n = n + 1;
    end
    return n;
endfunction

function automatic word_t shift_val(input logic [1:0] kind, input word_t v, input logic [4:0] amt);
    case (kind)
        2'b00:   return v << amt;
        2'b10:   return v >> amt;
        default: return word_t'($signed(v) >>> amt);
    endcase
endfunction

function automatic exp_t model_exec(input inst_t inst);
    exp_t       e;
    logic [5:0] op;
    logic [5:0] fn;
    reg_addr_t  rs;
    reg_addr_t  rt;
    reg_addr_t  rd;
    logic [4:0] sa;
    word_t      a;
    word_t      b;
    word_t      simm;
    word_t      zimm;
    op   = inst[31:26];
    rs   = inst[25:21];
    rt   = inst[20:16];
    rd   = inst[15:11];
    sa   = inst[10:6];
    fn   = inst[5:0];
    a    = model_regs[rs];
    b    = model_regs[rt];
    simm = {{16{inst[15]}}, inst[15:0]};
    zimm = {16'h0000, inst[15:0]};
    e         = '0;
    e.wen     = 1'b1;
    e.addr    = rt;
    case (op)
        6'h00:
        begin
            e.addr    = rd;
            e.illegal = (sa != 5'd0);
            case (fn)
                6'h24: e.data = a & b;
                6'h25: e.data = a | b;
                6'h26: e.data = a ^ b;
                6'h27: e.data = ~(a | b);
                6'h00, 6'h02, 6'h03:
                begin
                    e.illegal = (rs != 5'd0); // sa is the amount here
                    e.data    = shift_val(fn[1:0], b, sa);
                end
                6'h04, 6'h06, 6'h07: e.data = shift_val(fn[1:0], b, a[4:0]);
                6'h20, 6'h21: e.data = a + b;
                6'h22, 6'h23: e.data = a - b;
                6'h2a: e.data = word_t'($signed(a) < $signed(b));
                6'h2b: e.data = word_t'(a < b);
                6'h0a:
                begin
                    e.data = a; // movz
                    e.wen  = (b == '0);
                end
                6'h0b:
                begin
                    e.data = a; // movn
                    e.wen  = (b != '0);
                end
                default: e.illegal = 1'b1;
            endcase
        end
        6'h1c:
        begin
            e.addr = rd;
            case (fn)
                6'h20:   e.data = count_lead(a, 1'b0);
                6'h21:   e.data = count_lead(a, 1'b1);
                default: e.illegal = 1'b1;
            endcase
        end
        6'h0c: e.data = a & zimm;
        6'h0d: e.data = a | zimm;
        6'h0e: e.data = a ^ zimm;
        6'h0f: e.data = {inst[15:0], 16'h0000};
        6'h08, 6'h09: e.data = a + simm;
        6'h0a: e.data = word_t'($signed(a) < $signed(simm));
        6'h0b: e.data = word_t'(a < simm);
        default: e.illegal = 1'b1;
    endcase
    if (e.illegal || e.addr == 5'd0)
        e.wen = 1'b0;
    e.check_val = !e.illegal;
    if (e.wen)
        model_regs[e.addr] = e.data;
    return e;
endfunction

`endif

// File: verification/mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb;
    import mips_pkg::*;

    localparam int WAIT_LIMIT = 64;

    logic        clk = 1'b0;
    logic        rst_n_i;
    logic        inst_valid_i;
    inst_t       inst_i;
    logic        res_valid_o;
    logic        res_wen_o;
    reg_addr_t   res_addr_o;
    word_t       res_data_o;
    logic        res_illegal_o;

    int          seed;
    int unsigned cycle = 0;
    int          errors = 0;
    int          results = 0;
    int          res_mark;
    int          err_mark;

    `include "mips_model.svh"

    exp_t exp_q [$];

    mips_core UUT (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .inst_valid_i  (inst_valid_i),
        .inst_i        (inst_i),
        .res_valid_o   (res_valid_o),
        .res_wen_o     (res_wen_o),
        .res_addr_o    (res_addr_o),
        .res_data_o    (res_data_o),
        .res_illegal_o (res_illegal_o)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
        cycle <= cycle + 1;

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    // outputs are sampled mid cycle
    always @(negedge clk)
    begin
        exp_t e;
        if (res_valid_o === 1'b1)
        begin
            if (exp_q.size() == 0)
            begin
                $display("%0t: a result came out with no instruction outstanding", $time);
                errors++;
            end
            else
            begin
                e = exp_q.pop_front();
                results++;
                if (cycle != e.due)
                begin
                    $display("%0t: result arrived in cycle %0d instead of %0d", $time, cycle, e.due);
                    errors++;
                end
                check_flag("res_wen_o", res_wen_o, e.wen);
                check_flag("res_illegal_o", res_illegal_o, e.illegal);
                if (e.check_val)
                begin
                    check_addr("res_addr_o", res_addr_o, e.addr);
                    check_word("res_data_o", res_data_o, e.data);
                end
            end
        end
        else if (res_wen_o === 1'b1 || res_illegal_o === 1'b1)
        begin
            $display("%0t: write or illegal flag raised without a valid result", $time);
            errors++;
        end
    end

    function automatic int pick(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r % n);
    endfunction

    function automatic reg_addr_t rand_reg();
        return reg_addr_t'(pick(8)); // r0..r7 keeps dependencies frequent
    endfunction

    function automatic logic [15:0] rand_imm();
        logic [31:0] r;
        r = $random(seed);
        return r[15:0];
    endfunction

    function automatic int rand_gap(input int max_gap);
        if (max_gap == 0 || pick(3) != 0)
            return 0;
        return 1 + pick(max_gap);
    endfunction

    function automatic inst_t rtype(input logic [5:0] fn, input reg_addr_t rs, input reg_addr_t rt,
                                    input reg_addr_t rd, input logic [4:0] sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic inst_t itype(input logic [5:0] op, input reg_addr_t rs, input reg_addr_t rt,
                                    input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic inst_t special2(input logic [5:0] fn, input reg_addr_t rs, input reg_addr_t rd);
        return {OP_SPECIAL2, rs, rd, rd, 5'd0, fn};
    endfunction

    function automatic inst_t rand_logic();
        case (pick(8))
            0: return rtype(FN_OR, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            1: return rtype(FN_AND, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            2: return rtype(FN_XOR, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            3: return rtype(FN_NOR, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            4: return itype(OP_ORI, rand_reg(), rand_reg(), rand_imm());
            5: return itype(OP_ANDI, rand_reg(), rand_reg(), rand_imm());
            6: return itype(OP_XORI, rand_reg(), rand_reg(), rand_imm());
            default: return itype(OP_LUI, 5'd0, rand_reg(), rand_imm());
        endcase
    endfunction

    function automatic inst_t rand_shift();
        case (pick(6))
            0: return rtype(FN_SLL, 5'd0, rand_reg(), rand_reg(), 5'(pick(32)));
            1: return rtype(FN_SRL, 5'd0, rand_reg(), rand_reg(), 5'(pick(32)));
            2: return rtype(FN_SRA, 5'd0, rand_reg(), rand_reg(), 5'(pick(32)));
            3: return rtype(FN_SLLV, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            4: return rtype(FN_SRLV, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            default: return rtype(FN_SRAV, rand_reg(), rand_reg(), rand_reg(), 5'd0);
        endcase
    endfunction

    function automatic inst_t rand_arith();
        case (pick(12))
            0: return rtype(FN_ADD, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            1: return rtype(FN_ADDU, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            2: return rtype(FN_SUB, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            3: return rtype(FN_SUBU, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            4: return rtype(FN_SLT, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            5: return rtype(FN_SLTU, rand_reg(), rand_reg(), rand_reg(), 5'd0);
            6: return itype(OP_ADDI, rand_reg(), rand_reg(), rand_imm());
            7: return itype(OP_ADDIU, rand_reg(), rand_reg(), rand_imm());
            8: return itype(OP_SLTI, rand_reg(), rand_reg(), rand_imm());
            9: return itype(OP_SLTIU, rand_reg(), rand_reg(), rand_imm());
            10: return special2(FN_CLZ, rand_reg(), rand_reg());
            default: return special2(FN_CLO, rand_reg(), rand_reg());
        endcase
    endfunction

    function automatic inst_t rand_move();
        return rtype(pick(2) ? FN_MOVN : FN_MOVZ, rand_reg(), rand_reg(), rand_reg(), 5'd0);
    endfunction

    function automatic inst_t rand_legal();
        case (pick(4))
            0: return rand_logic();
            1: return rand_shift();
            2: return rand_arith();
            default: return rand_move();
        endcase
    endfunction

    task automatic report_timeout(input string why);
        $display("%0t: %s", $time, why);
        errors++;
    endtask

    task automatic issue(input inst_t inst);
        exp_t e;
        @(posedge clk);
        inst_valid_i <= 1'b1;
        inst_i       <= inst;
        e     = model_exec(inst);
        e.due = cycle + 4; // sampled on the next edge, reported two edges later
        exp_q.push_back(e);
    endtask

    task automatic idle(input int n);
        repeat (n)
        begin
            @(posedge clk);
            inst_valid_i <= 1'b0;
            inst_i       <= $random(seed); // must be ignored
        end
    endtask

    task automatic load_regs();
        for (int r = 1; r < 8; r++)
        begin
            issue(itype(OP_LUI, 5'd0, reg_addr_t'(r), rand_imm()));
            issue(itype(OP_ORI, reg_addr_t'(r), reg_addr_t'(r), rand_imm()));
        end
    endtask

    task automatic wait_reset_release();
        int waited;
        waited = 0;
        while (rst_n_i !== 1'b1 && waited < WAIT_LIMIT)
        begin
            @(posedge clk);
            waited++;
        end
        if (rst_n_i !== 1'b1)
            report_timeout("reset was never released");
    endtask

    task automatic finish_test(input string name);
        int waited;
        @(posedge clk);
        inst_valid_i <= 1'b0;
        waited = 0;
        while (exp_q.size() != 0 && waited < WAIT_LIMIT)
        begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            report_timeout($sformatf("%s: %0d results never came out", name, exp_q.size()));
            exp_q.delete();
        end
        $display("%s: %0d results, %0d errors", name, results - res_mark, errors - err_mark);
        res_mark = results;
        err_mark = errors;
    endtask

    initial
    begin
        rst_n_i      = 1'b0;
        inst_valid_i = 1'b0;
        inst_i       = '0;
        seed         = 32'hd182_9fd0;
        res_mark     = 0;
        err_mark     = 0;
        for (int i = 0; i < REG_COUNT; i++)
            model_regs[i] = '0;
        repeat (8) @(posedge clk);
        rst_n_i <= 1'b1;
        wait_reset_release();

        idle(4); // no result may appear yet
        for (int i = 0; i < REG_COUNT; i++)
            issue(rtype(FN_OR, reg_addr_t'(i), 5'd0, 5'd1, 5'd0));
        finish_test("reset");

        load_regs();
        repeat (60)
        begin
            issue(rand_logic());
            idle(rand_gap(2));
        end
        finish_test("logic");

        load_regs();
        repeat (60)
        begin
            issue(rand_shift());
            idle(rand_gap(2));
        end
        finish_test("shifts");

        load_regs();
        issue(itype(OP_LUI, 5'd0, 5'd3, 16'h7fff));
        issue(itype(OP_ORI, 5'd3, 5'd3, 16'hffff));
        issue(rtype(FN_ADD, 5'd3, 5'd3, 5'd4, 5'd0)); // wraps
        issue(itype(OP_SLTIU, 5'd1, 5'd2, 16'hfff0)); // negative imm, huge unsigned
        issue(special2(FN_CLZ, 5'd0, 5'd5));
        issue(itype(OP_ADDIU, 5'd0, 5'd6, 16'hffff));
        issue(special2(FN_CLO, 5'd6, 5'd6));
        repeat (60)
        begin
            issue(rand_arith());
            idle(rand_gap(2));
        end
        finish_test("arithmetic");

        issue(itype(OP_ADDIU, 5'd0, 5'd1, 16'd5));
        issue(rtype(FN_ADDU, 5'd1, 5'd1, 5'd2, 5'd0));
        issue(rtype(FN_ADDU, 5'd2, 5'd1, 5'd3, 5'd0));
        idle(1);
        issue(rtype(FN_SUBU, 5'd3, 5'd2, 5'd4, 5'd0));
        issue(itype(OP_ADDIU, 5'd0, 5'd0, 16'd7)); // r0 target
        issue(rtype(FN_OR, 5'd0, 5'd0, 5'd5, 5'd0));
        repeat (80)
        begin
            issue(rand_legal());
            idle(pick(2));
        end
        finish_test("forwarding");

        issue(rtype(FN_ADDU, 5'd0, 5'd0, 5'd7, 5'd0));
        repeat (40)
        begin
            issue(pick(2) ? rand_move() : rand_legal());
            idle(rand_gap(1));
        end
        issue(rtype(6'h18, 5'd1, 5'd2, 5'd0, 5'd0)); // mult
        issue(rtype(6'h10, 5'd0, 5'd0, 5'd3, 5'd0)); // mfhi
        issue(rtype(6'h0f, 5'd0, 5'd0, 5'd0, 5'd0)); // sync
        issue(itype(6'h33, 5'd1, 5'd4, 16'h0010));   // pref
        repeat (60)
        begin
            issue($random(seed));
            idle(rand_gap(2));
        end
        finish_test("moves and illegal");

        $display("%0d results checked, %0d errors", results, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: project.f
+incdir+verification
hw/mips_pkg.sv
hw/mips_decode.sv
hw/mips_execute.sv
hw/mips_result.sv
hw/mips_core.sv
verification/mips_core_tb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = mips_core_tb
FILELIST = project.f
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST))
HDRS     = verification/mips_model.svh

.PHONY: all run check clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Simulation passed$$" $(LOG)

check:
	@grep -q "^Simulation passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
